// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_quad_bram_ctrl
FILELIST  ?= quad_bram_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) dv/tb_tasks.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_tasks.svh ====
// Compare one value, report in hex on mismatch
function automatic void check_value(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
    if (got !== exp) begin
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endfunction

// Cycle budget of one job: priming fetches, reads, slack
function automatic int job_cycles(input int cols, input int rows, input int passes);
    return PRIME_ROWS * (cols + 17) + CYC_PER_PIX * (cols + 1) * (rows + 1) * passes + 50;
endfunction

function automatic void clear_counters();
    req_count = 0;
    rden_count = 0;
    exp_col = 0;
    exp_row = 0;
    read_idx = 0;
    rden_total = 0;
    exec_count = 0;
    nk_count = 0;
    nk7_count = 0;
    first_rden_cyc = 0;
    first_exec_cyc = 0;
endfunction

// All control outputs stay low with no job_start
task automatic reset_quiet_test();
    repeat (5) begin
        @(negedge clk);
        check_value("job_accept", job_accept, 0);
        check_value("job_fetch_request", job_fetch_request, 0);
        check_value("job_fetch_in_progress", job_fetch_in_progress, 0);
        check_value("job_complete", job_complete, 0);
        check_value("pfb_rden", pfb_rden, 0);
        check_value("pix_seq_bram_rden", pix_seq_bram_rden, 0);
        check_value("ce_execute", ce_execute, 0);
        check_value("next_kernel", next_kernel, 0);
    end
endtask

// Completion ack after a random hold
task automatic complete_job();
    int d;
    d = $urandom_range(1, 6);
    repeat (d) begin
        @(negedge clk);
        check_value("job_complete", job_complete, 1);
    end
    @(posedge clk);
    job_complete_ack <= 1'b1;
    @(posedge clk);
    job_complete_ack <= 1'b0;
    @(negedge clk);
    check_value("job_complete", job_complete, 0);
endtask

// One full job: accept, priming, reads, chains, completion
task automatic run_job(input int cols, input int rows, input int slen, input bit alt);
    int passes;
    passes = alt ? 2 * (rows + 1) : rows + 1;
    @(posedge clk);
    num_input_cols <= DIM_W'(cols);
    num_input_rows <= DIM_W'(rows);
    seq_length <= SEQ_ADDR_W'(slen);
    pfb_full_count <= PFB_CNT_W'(cols + 1);
    alt_kernel = alt;
    clear_counters();
    reads_exp = CYC_PER_PIX * (cols + 1) * passes;
    seq_len_cur = slen;
    @(posedge clk);
    job_start <= 1'b1;
    @(negedge clk);
    check_value("job_accept", job_accept, 0);
    @(posedge clk);
    job_start <= 1'b0;
    @(negedge clk);
    check_value("job_accept", job_accept, 1);
    @(negedge clk);
    check_value("job_accept", job_accept, 0);
    while (!job_complete) @(negedge clk);
    check_value("fetch requests", req_count, PRIME_ROWS);
    check_value("pfb_rden count", rden_count, PRIME_ROWS * (cols + 1));
    check_value("input_row", input_row, PRIME_ROWS);
    check_value("sequence reads", read_idx, reads_exp);
    check_value("pix_seq_bram_rden cycles", rden_total, reads_exp + SEQ_RD_LATENCY);
    check_value("ce_execute[0] latency", first_exec_cyc - first_rden_cyc, SEQ_RD_LATENCY);
    check_value("ce_execute[0] cycles", exec_count, reads_exp);
    check_value("next_kernel[0] pulses", nk_count, passes);
    check_value("next_kernel[7] pulses", nk7_count, passes);
    complete_job();
endtask

// ==== dv/tb_quad_bram_ctrl.sv ====
`timescale 1ns/10ps

module tb_quad_bram_ctrl import quad_ctrl_pkg::*; ();

    logic                  clk;
    logic                  rst;
    logic [DIM_W-1:0]      num_input_cols;
    logic [DIM_W-1:0]      num_input_rows;
    logic [SEQ_ADDR_W-1:0] seq_length;
    logic                  job_start;
    logic                  job_accept;
    logic                  job_fetch_request;
    logic                  job_fetch_in_progress;
    logic                  job_fetch_ack;
    logic                  job_fetch_complete;
    logic [PFB_CNT_W-1:0]  pfb_full_count;
    logic                  job_complete;
    logic                  job_complete_ack;
    logic                  pfb_rden;
    logic [DIM_W-1:0]      input_row;
    logic [DIM_W-1:0]      input_col;
    logic                  pix_seq_bram_rden;
    logic [SEQ_ADDR_W-1:0] pix_seq_bram_rd_addr;
    logic [CYC_W-1:0]      cycle_counter;
    logic [NUM_CE-1:0]     ce_execute;
    logic [NUM_CE-1:0]     next_kernel;
    logic                  last_kernel;

    // Run bookkeeping
    int errors;
    int cycle;
    int timeout_limit;
    bit alt_kernel;

    // Monitor counters, cleared per job
    int  req_count;
    int  rden_count;
    int  exp_col;
    int  exp_row;
    int  read_idx;
    int  reads_exp;
    int  seq_len_cur;
    int  rden_total;
    int  exec_count;
    int  nk_count;
    int  nk7_count;
    int  first_rden_cyc;
    int  first_exec_cyc;
    logic req_prev;
    logic [NUM_CE-1:0] ce_hist;
    logic [NUM_CE-1:0] nk_hist;

    quad_bram_ctrl DUT (.*);

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fetch responder with random ack and complete delays
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int d;
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && job_fetch_request) begin
                d = $urandom_range(1, 6);
                repeat (d) @(posedge clk);
                job_fetch_ack <= 1'b1;
                @(posedge clk);
                job_fetch_ack <= 1'b0;
                @(negedge clk);
                // Request gone, fetch under way
                check_value("job_fetch_request", job_fetch_request, 0);
                check_value("job_fetch_in_progress", job_fetch_in_progress, 1);
                d = $urandom_range(1, 6);
                repeat (d) @(posedge clk);
                job_fetch_complete <= 1'b1;
                @(posedge clk);
                job_fetch_complete <= 1'b0;
            end
        end
    end

    // Kernel flag drops on every other row wrap in the repeat test
    always @(posedge clk) begin
        if (alt_kernel) begin
            last_kernel <= nk_count[0];
        end else begin
            last_kernel <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            if (job_fetch_request && !req_prev) req_count++;
            req_prev = job_fetch_request;
            if (pfb_rden) begin
                check_value("input_col", input_col, exp_col);
                check_value("input_row", input_row, exp_row);
                rden_count++;
                if (exp_col == int'(num_input_cols)) begin
                    exp_col = 0;
                    exp_row++;
                end else begin
                    exp_col++;
                end
            end
            if (pix_seq_bram_rden) begin
                if (rden_total == 0) first_rden_cyc = cycle;
                rden_total++;
                // Only the first reads_exp cycles are real reads
                if (read_idx < reads_exp) begin
                    check_value("pix_seq_bram_rd_addr", pix_seq_bram_rd_addr,
                                read_idx % seq_len_cur);
                    check_value("cycle_counter", cycle_counter, read_idx % CYC_PER_PIX);
                    read_idx++;
                end
            end
            if (ce_execute[0]) begin
                if (exec_count == 0) first_exec_cyc = cycle;
                exec_count++;
            end
            if (next_kernel[0]) nk_count++;
            if (next_kernel[NUM_CE-1]) nk7_count++;
            for (int k = 1; k < NUM_CE; k++) begin
                check_value($sformatf("ce_execute[%0d]", k), ce_execute[k], ce_hist[k-1]);
                check_value($sformatf("next_kernel[%0d]", k), next_kernel[k], nk_hist[k-1]);
            end
            ce_hist = {ce_hist[NUM_CE-2:0], ce_execute[0]};
            nk_hist = {nk_hist[NUM_CE-2:0], next_kernel[0]};
        end
    end

    // Cycle count and timeout
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (timeout_limit > 0 && cycle >= timeout_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle);
            $display("Errors: %0d", errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h9c7903ac));
        errors = 0;
        cycle = 0;
        alt_kernel = 1'b0;
        req_prev = 1'b0;
        ce_hist = '0;
        nk_hist = '0;
        clear_counters();
        timeout_limit = 2 * (job_cycles(7, 3, 1) + job_cycles(4, 2, 2)
                             + job_cycles(5, 1, 1) + 20);
        rst = 1'b1;
        num_input_cols = '0;
        num_input_rows = '0;
        seq_length = '0;
        job_start = 1'b0;
        pfb_full_count = '0;
        job_complete_ack = 1'b0;
        last_kernel = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        reset_quiet_test();
        run_job(7, 3, 12, 1'b0);
        run_job(4, 2, 7, 1'b1);
        run_job(5, 1, 20, 1'b0);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/ce_dispatch.sv ====
`timescale 1ns/10ps

module ce_dispatch import quad_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              seq_rd,
    input  logic              row_wrap,
    output logic [NUM_CE-1:0] ce_execute,
    output logic [NUM_CE-1:0] next_kernel,
    output logic              ce_busy
);

    // Read latency stages followed by one stage per engine
    logic [SEQ_RD_LATENCY+NUM_CE-2:0] exec_line;

    // Engine k sees the read SEQ_RD_LATENCY+k cycles later
    assign ce_execute = exec_line[SEQ_RD_LATENCY+NUM_CE-2:SEQ_RD_LATENCY-1];

    // Busy also covers reads still in flight and pending kernel strobes
    assign ce_busy = (|exec_line) || (|next_kernel);

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_line   <= '0;
            next_kernel <= '0;
        end else begin
            exec_line   <= {exec_line[SEQ_RD_LATENCY+NUM_CE-3:0], seq_rd};
            // Kernel switch ripples down the engines one per cycle
            next_kernel <= {next_kernel[NUM_CE-2:0], row_wrap};
        end
    end

endmodule

// ==== logic/job_sequencer.sv ====
`timescale 1ns/10ps

module job_sequencer import quad_ctrl_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             job_start,
    input  logic             job_complete_ack,
    input  logic             buf_empty,
    input  logic [DIM_W-1:0] input_row,
    input  logic             fetch_done,
    input  logic             frame_done,
    input  logic             ce_busy,
    output logic             job_accept,
    output logic             job_complete,
    output logic             fetch_start,
    output logic             prime_en,
    output logic             seq_run,
    output logic             job_begin
);

    ctrl_state_t state;
    logic        complete_acked;

    // Buffer reads only while priming
    assign prime_en = (state == PRIME);

    // New job clears the sequence read position
    assign job_begin = job_accept;

    ////////////////////////////////////////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= IDLE;
            job_accept     <= 1'b0;
            job_complete   <= 1'b0;
            fetch_start    <= 1'b0;
            seq_run        <= 1'b0;
            complete_acked <= 1'b0;
        end else begin
            // Single-cycle strobes
            job_accept  <= 1'b0;
            fetch_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (job_start) begin
                        job_accept  <= 1'b1;
                        fetch_start <= 1'b1;
                        state       <= PRIME;
                    end
                end
                PRIME: begin
                    // Buffer drained, either primed or needs another row
                    if (buf_empty && input_row == DIM_W'(PRIME_ROWS)) begin
                        state <= ACTIVE;
                    end else if (buf_empty && input_row < DIM_W'(PRIME_ROWS)) begin
                        fetch_start <= 1'b1;
                        state       <= WAIT_LOAD;
                    end
                end
                WAIT_LOAD: begin
                    if (fetch_done) begin
                        state <= PRIME;
                    end
                end
                ACTIVE: begin
                    // Reads start the cycle after entry, stop on the last pixel
                    seq_run <= !frame_done;
                    if (frame_done) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // Let the engine chains empty out
                    if (!ce_busy) begin
                        job_complete <= 1'b1;
                        state        <= DONE;
                    end
                end
                DONE: begin
                    // One settle cycle after the ack before a new job
                    if (complete_acked) begin
                        complete_acked <= 1'b0;
                        state          <= IDLE;
                    end else if (job_complete_ack) begin
                        job_complete   <= 1'b0;
                        complete_acked <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // State register never leaves the encoded set
    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, PRIME, WAIT_LOAD, ACTIVE, DRAIN, DONE});

endmodule

// ==== logic/output_tracker.sv ====
`timescale 1ns/10ps

module output_tracker import quad_ctrl_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             pixel_done,
    input  logic             last_kernel,
    input  logic [DIM_W-1:0] num_input_cols,
    input  logic [DIM_W-1:0] num_input_rows,
    output logic             row_wrap,
    output logic             frame_done
);

    logic [DIM_W-1:0] output_row;
    logic [DIM_W-1:0] output_col;

    // End of an output row, once per kernel pass
    assign row_wrap = pixel_done && (output_col == num_input_cols);

    // Last row done with the final kernel
    assign frame_done = row_wrap && last_kernel && (output_row == num_input_rows);

    ////////////////////////////////////////////////////////////////////////////
    // Output position
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || frame_done) begin
            output_row <= '0;
            output_col <= '0;
        end else if (row_wrap) begin
            output_col <= '0;
            // Same row again until all kernels have passed
            if (last_kernel) begin
                output_row <= output_row + 1'b1;
            end
        end else if (pixel_done) begin
            output_col <= output_col + 1'b1;
        end
    end

endmodule

// ==== logic/pfb_fetch.sv ====
`timescale 1ns/10ps

module pfb_fetch import quad_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_start,
    input  logic                 job_fetch_ack,
    input  logic                 job_fetch_complete,
    input  logic [PFB_CNT_W-1:0] pfb_full_count,
    input  logic                 prime_en,
    input  logic [DIM_W-1:0]     num_input_cols,
    output logic                 job_fetch_request,
    output logic                 job_fetch_in_progress,
    output logic                 fetch_done,
    output logic                 pfb_rden,
    output logic                 buf_empty,
    output logic [DIM_W-1:0]     input_row,
    output logic [DIM_W-1:0]     input_col
);

    logic [PFB_CNT_W-1:0] pfb_count;

    // Completion only counts once the fetch is under way
    assign fetch_done = job_fetch_complete && job_fetch_in_progress;

    // One buffer word per cycle while priming
    assign pfb_rden = prime_en && !job_fetch_in_progress && (pfb_count != '0);

    // Empty means nothing left and nothing on its way
    assign buf_empty = (pfb_count == '0) && !fetch_start && !job_fetch_request
                       && !job_fetch_in_progress;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch handshake and fill count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_request     <= 1'b0;
            job_fetch_in_progress <= 1'b0;
            pfb_count             <= '0;
        end else begin
            if (fetch_start) begin
                job_fetch_request <= 1'b1;
            end else if (job_fetch_ack && job_fetch_request) begin
                job_fetch_request     <= 1'b0;
                job_fetch_in_progress <= 1'b1;
            end
            if (fetch_done) begin
                job_fetch_in_progress <= 1'b0;
                pfb_count             <= pfb_full_count;
            end else if (pfb_rden) begin
                pfb_count <= pfb_count - 1'b1;
            end
        end
    end

    // Input position advances one column per buffer read
    always_ff @(posedge clk) begin
        if (rst) begin
            input_row <= '0;
            input_col <= '0;
        end else if (fetch_start && input_row >= DIM_W'(PRIME_ROWS)) begin
            // Fetch with a primed buffer opens a new job
            input_row <= '0;
            input_col <= '0;
        end else if (pfb_rden) begin
            if (input_col == num_input_cols) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else begin
                input_col <= input_col + 1'b1;
            end
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        job_fetch_ack |-> job_fetch_request);

    // Refill lands only after every buffered word has been read
    a_reload_when_empty: assert property (@(posedge clk) disable iff (rst)
        fetch_done |-> pfb_count == '0);

endmodule

// ==== logic/quad_bram_ctrl.sv ====
`timescale 1ns/10ps

module quad_bram_ctrl import quad_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DIM_W-1:0]      num_input_cols,
    input  logic [DIM_W-1:0]      num_input_rows,
    input  logic [SEQ_ADDR_W-1:0] seq_length,
    input  logic                  job_start,
    output logic                  job_accept,
    output logic                  job_fetch_request,
    output logic                  job_fetch_in_progress,
    input  logic                  job_fetch_ack,
    input  logic                  job_fetch_complete,
    input  logic [PFB_CNT_W-1:0]  pfb_full_count,
    output logic                  job_complete,
    input  logic                  job_complete_ack,
    output logic                  pfb_rden,
    output logic [DIM_W-1:0]      input_row,
    output logic [DIM_W-1:0]      input_col,
    output logic                  pix_seq_bram_rden,
    output logic [SEQ_ADDR_W-1:0] pix_seq_bram_rd_addr,
    output logic [CYC_W-1:0]      cycle_counter,
    output logic [NUM_CE-1:0]     ce_execute,
    output logic [NUM_CE-1:0]     next_kernel,
    input  logic                  last_kernel
);

    // Sequencer controls
    logic fetch_start;
    logic prime_en;
    logic seq_run;
    logic job_begin;

    // Status back to the sequencer
    logic fetch_done;
    logic buf_empty;
    logic frame_done;
    logic ce_busy;

    // Read and pixel strobes
    logic seq_rd;
    logic pixel_done;
    logic row_wrap;

    job_sequencer u_job_sequencer (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .job_complete_ack (job_complete_ack),
        .buf_empty        (buf_empty),
        .input_row        (input_row),
        .fetch_done       (fetch_done),
        .frame_done       (frame_done),
        .ce_busy          (ce_busy),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .fetch_start      (fetch_start),
        .prime_en         (prime_en),
        .seq_run          (seq_run),
        .job_begin        (job_begin)
    );

    pfb_fetch u_pfb_fetch (
        .clk                   (clk),
        .rst                   (rst),
        .fetch_start           (fetch_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .pfb_full_count        (pfb_full_count),
        .prime_en              (prime_en),
        .num_input_cols        (num_input_cols),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .fetch_done            (fetch_done),
        .pfb_rden              (pfb_rden),
        .buf_empty             (buf_empty),
        .input_row             (input_row),
        .input_col             (input_col)
    );

    seq_reader u_seq_reader (
        .clk                  (clk),
        .rst                  (rst),
        .seq_run              (seq_run),
        .job_begin            (job_begin),
        .seq_length           (seq_length),
        .seq_rd               (seq_rd),
        .pixel_done           (pixel_done),
        .cycle_counter        (cycle_counter),
        .pix_seq_bram_rden    (pix_seq_bram_rden),
        .pix_seq_bram_rd_addr (pix_seq_bram_rd_addr)
    );

    output_tracker u_output_tracker (
        .clk            (clk),
        .rst            (rst),
        .pixel_done     (pixel_done),
        .last_kernel    (last_kernel),
        .num_input_cols (num_input_cols),
        .num_input_rows (num_input_rows),
        .row_wrap       (row_wrap),
        .frame_done     (frame_done)
    );

    ce_dispatch u_ce_dispatch (
        .clk         (clk),
        .rst         (rst),
        .seq_rd      (seq_rd),
        .row_wrap    (row_wrap),
        .ce_execute  (ce_execute),
        .next_kernel (next_kernel),
        .ce_busy     (ce_busy)
    );

endmodule

// ==== logic/quad_ctrl_pkg.sv ====
package quad_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////

    // Row and column positions, also the dimension inputs
    localparam int DIM_W = 9;

    // 4 AWEs with 2 compute engines each
    localparam int NUM_CE = 8;

    // Sequence reads that make up one output pixel
    localparam int CYC_PER_PIX = 5;
    localparam int CYC_W = 3;

    // Input rows held in the buffer before execution starts
    localparam int PRIME_ROWS = 4;

    // Sequence BRAM read strobe to execute strobe
    localparam int SEQ_RD_LATENCY = 3;
    localparam int SEQ_ADDR_W = 12;

    // Prefetch buffer fill count
    localparam int PFB_CNT_W = 9;

    ////////////////////////////////////////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        PRIME,
        WAIT_LOAD,
        ACTIVE,
        DRAIN,
        DONE
    } ctrl_state_t;

endpackage

// ==== logic/seq_reader.sv ====
`timescale 1ns/10ps

module seq_reader import quad_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  seq_run,
    input  logic                  job_begin,
    input  logic [SEQ_ADDR_W-1:0] seq_length,
    output logic                  seq_rd,
    output logic                  pixel_done,
    output logic [CYC_W-1:0]      cycle_counter,
    output logic                  pix_seq_bram_rden,
    output logic [SEQ_ADDR_W-1:0] pix_seq_bram_rd_addr
);

    // Read strobe history across the BRAM latency
    logic [SEQ_RD_LATENCY-1:0] rd_dly;

    // One read every cycle of the run
    assign seq_rd = seq_run;

    // Last read of the current pixel
    assign pixel_done = seq_rd && (cycle_counter == CYC_W'(CYC_PER_PIX - 1));

    // Enable held until the last read's data is out
    assign pix_seq_bram_rden = seq_rd || rd_dly[SEQ_RD_LATENCY-1];

    ////////////////////////////////////////////////////////////////////////////
    // Address and per-pixel counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || job_begin) begin
            pix_seq_bram_rd_addr <= '0;
            cycle_counter        <= '0;
        end else if (seq_rd) begin
            // Sequence table wraps per pixel group
            if (pix_seq_bram_rd_addr == seq_length - 1'b1) begin
                pix_seq_bram_rd_addr <= '0;
            end else begin
                pix_seq_bram_rd_addr <= pix_seq_bram_rd_addr + 1'b1;
            end
            if (pixel_done) begin
                cycle_counter <= '0;
            end else begin
                cycle_counter <= cycle_counter + 1'b1;
            end
        end
    end

    // Latency delay line
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_dly <= '0;
        end else begin
            rd_dly <= {rd_dly[SEQ_RD_LATENCY-2:0], seq_rd};
        end
    end

endmodule

// ==== quad_bram_ctrl.f ====
+incdir+dv
logic/quad_ctrl_pkg.sv
logic/job_sequencer.sv
logic/pfb_fetch.sv
logic/seq_reader.sv
logic/output_tracker.sv
logic/ce_dispatch.sv
logic/quad_bram_ctrl.sv
dv/tb_quad_bram_ctrl.sv
